/* verification/hierarchy_patterns.txt */
# port(I/D) rw addr wdata expected, all hex, expected is ignored on writes
# B inst_addr inst_expected data_addr data_expected raises both reads together
D 0 000010 00000000 5a000010
D 0 000010 00000000 5a000010
I 0 000010 00000000 5a000010
I 0 000010 00000000 5a000010
D 1 000010 11110010 00000000
D 0 000010 00000000 11110010
D 1 000030 33330030 00000000
D 0 000030 00000000 33330030
D 0 000070 00000000 5a000070
D 0 000030 00000000 33330030
I 0 000030 00000000 33330030
D 1 000030 44440030 00000000
I 0 000070 00000000 5a000070
I 0 000030 00000000 44440030
D 1 000105 55550105 00000000
I 0 000105 00000000 55550105
B 000200 5a000200 000341 5a000341
I 0 000200 00000000 5a000200
D 0 000341 00000000 5a000341
B 000200 5a000200 000341 5a000341
D 0 000fff 00000000 5a000fff
D 0 001000 00000000 00000000
D 0 001000 00000000 00000000
I 0 001234 00000000 00000000

/* project.f */
source/cache_pkg.sv
source/l1_cache.sv
source/miss_arbiter.sv
source/l2_cache.sv
source/ext_mem_controller.sv
source/mem_hierarchy_top.sv
verification/clock_gen.sv
verification/ext_mem_model.sv
verification/tb_mem_hierarchy.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory hierarchy testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_hierarchy -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verification/tb_mem_hierarchy.sv */
// memory hierarchy testbench

module tb_mem_hierarchy;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int L1_LINES     = 16;
	localparam int L2_LINES     = 64;
	localparam int MEM_WORDS    = 4096;
	localparam int MEM_TIMEOUT  = 64;
	localparam int DONE_TIMEOUT = 200;
	localparam int DRIVE_DELAY  = 10;

	logic                clock;
	logic                rst;
	cache_pkg::mem_req_t inst_req;
	cache_pkg::mem_req_t data_req;
	cache_pkg::mem_rsp_t inst_rsp;
	cache_pkg::mem_rsp_t data_rsp;
	logic                mem_req;
	logic                mem_rw;
	logic                mem_done;
	cache_pkg::addr_t    mem_add;
	cache_pkg::word_t    mem_wdata;
	cache_pkg::word_t    mem_rdata;
	logic [1:0]          exception;
	logic [95:0]         hit_counts;

	// reference tag model with port 0 as inst and port 1 as data
	logic             l1_valid [2][L1_LINES];
	cache_pkg::addr_t l1_addr  [2][L1_LINES];
	logic             l2_valid [L2_LINES];
	cache_pkg::addr_t l2_addr  [L2_LINES];
	int               l1_hits  [2];
	int               l2_hits;
	logic [1:0]       exc_expected;

	clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) clocks (.clock_o(clock), .rst_o(rst));

	ext_mem_model #(.WORDS(MEM_WORDS)) memory (
		.clock_i(clock), .rst_i(rst),
		.mem_req_i(mem_req), .mem_rw_i(mem_rw), .mem_add_i(mem_add),
		.mem_data_i(mem_wdata), .mem_data_o(mem_rdata), .mem_done_o(mem_done)
	);

	mem_hierarchy_top #(
		.L1_LINES(L1_LINES), .L2_LINES(L2_LINES),
		.MEM_WORDS(MEM_WORDS), .MEM_TIMEOUT(MEM_TIMEOUT)
	) mem_hierarchy_top_i (
		.clock_i(clock), .rst_i(rst),
		.inst_req_i(inst_req), .inst_rsp_o(inst_rsp),
		.data_req_i(data_req), .data_rsp_o(data_rsp),
		.mem_req_o(mem_req), .mem_rw_o(mem_rw),
		.mem_add_o(mem_add), .mem_data_o(mem_wdata),
		.mem_data_i(mem_rdata), .mem_done_i(mem_done),
		.exception_o(exception), .hit_counts_o(hit_counts)
	);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check_value(input logic [95:0] actual, input logic [95:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
				$time, msg, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout at %0d ns while waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	// returns the predicted L1 hit and updates the model
	function automatic logic predict_read(input int p, input cache_pkg::addr_t a);
		int  i1;
		int  i2;
		logic hit;
		i1  = int'(a) % L1_LINES;
		i2  = int'(a) % L2_LINES;
		hit = l1_valid[p][i1] && (l1_addr[p][i1] == a);
		if (hit) begin
			l1_hits[p]++;
		end else begin
			l1_valid[p][i1] = 1'b1;
			l1_addr[p][i1]  = a;
			if (l2_valid[i2] && (l2_addr[i2] == a)) begin
				l2_hits++;
			end else if (int'(a) < MEM_WORDS) begin
				l2_valid[i2] = 1'b1;
				l2_addr[i2]  = a;
			end
		end
		return hit;
	endfunction

	task automatic set_req(input int p, input logic v, input logic rw,
		input cache_pkg::addr_t a, input cache_pkg::word_t d);
		cache_pkg::mem_req_t r;
		r.valid = v;
		r.rw    = rw;
		r.addr  = a;
		r.data  = d;
		if (p == 0) begin
			inst_req = r;
		end else begin
			data_req = r;
		end
	endtask

	// cycles counts the edges between the request and done
	task automatic wait_done(input int p, output cache_pkg::word_t data, output int cycles);
		logic done;
		cycles = 0;
		data   = '0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = (p == 0) ? inst_rsp.done : data_rsp.done;
			if (done) begin
				data = (p == 0) ? inst_rsp.data : data_rsp.data;
			end else begin
				cycles++;
				if (cycles > DONE_TIMEOUT) begin
					timeout_fail($sformatf("done on port %0d", p));
				end
			end
		end
		@(posedge clock);
		#DRIVE_DELAY;
		set_req(p, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic check_result(input int p, input logic rw, input cache_pkg::addr_t a,
		input cache_pkg::word_t expected, input logic l1_hit, input cache_pkg::word_t got,
		input int cycles);
		if (!rw) begin
			check_value(got, expected, $sformatf("read data, port %0d addr %h", p, a));
			if (l1_hit) begin
				check_value(cycles, 1, $sformatf("L1 hit latency, port %0d addr %h", p, a));
			end
		end
		if (int'(a) >= MEM_WORDS) begin
			exc_expected[cache_pkg::EXC_ADDR_RANGE] = 1'b1;
		end
	endtask

	task automatic single_access(input int p, input logic rw, input cache_pkg::addr_t a,
		input cache_pkg::word_t d, input cache_pkg::word_t expected);
		logic             hit;
		cache_pkg::word_t got;
		int               cycles;
		check_value(exception, exc_expected, "exception before access");
		hit = rw ? 1'b0 : predict_read(p, a);
		@(posedge clock);
		#DRIVE_DELAY;
		set_req(p, 1'b1, rw, a, d);
		wait_done(p, got, cycles);
		check_result(p, rw, a, expected, hit, got, cycles);
	endtask

	// both ports raise a read in the same cycle
	task automatic pair_access(input cache_pkg::addr_t ai, input cache_pkg::word_t ei,
		input cache_pkg::addr_t ad, input cache_pkg::word_t ed);
		logic             hit_i;
		logic             hit_d;
		cache_pkg::word_t got_i;
		cache_pkg::word_t got_d;
		int               cyc_i;
		int               cyc_d;
		check_value(exception, exc_expected, "exception before paired access");
		// data wins the arbiter and reaches L2 first
		hit_d = predict_read(1, ad);
		hit_i = predict_read(0, ai);
		@(posedge clock);
		#DRIVE_DELAY;
		set_req(0, 1'b1, 1'b0, ai, '0);
		set_req(1, 1'b1, 1'b0, ad, '0);
		fork
			wait_done(0, got_i, cyc_i);
			wait_done(1, got_d, cyc_d);
		join
		check_result(0, 1'b0, ai, ei, hit_i, got_i, cyc_i);
		check_result(1, 1'b0, ad, ed, hit_d, got_d, cyc_d);
	endtask

	// ------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------
	always @(negedge clock) begin
		if (!rst) begin
			check_value(inst_rsp.done && !inst_req.valid, 0, "inst done without request");
			check_value(data_rsp.done && !data_req.valid, 0, "data done without request");
			check_value(mem_req && (32'(mem_add) >= MEM_WORDS), 0,
				"mem_req_o for out of range address");
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		integer           fd;
		integer           code;
		int               n;
		logic [63:0]      tok;
		logic [8*200-1:0] line_buf;
		logic             rw;
		cache_pkg::addr_t a;
		cache_pkg::addr_t a2;
		cache_pkg::word_t d;
		cache_pkg::word_t e;
		cache_pkg::word_t e2;

		inst_req     = '0;
		data_req     = '0;
		exc_expected = '0;
		l2_hits      = 0;
		l1_hits[0]   = 0;
		l1_hits[1]   = 0;
		for (int i = 0; i < L1_LINES; i++) begin
			l1_valid[0][i] = 1'b0;
			l1_valid[1][i] = 1'b0;
		end
		for (int i = 0; i < L2_LINES; i++) begin
			l2_valid[i] = 1'b0;
		end

		n = 0;
		while (rst !== 1'b0) begin
			@(posedge clock);
			n++;
			if (n > 20) begin
				timeout_fail("reset release");
			end
		end
		#DRIVE_DELAY;
		check_value(inst_rsp.done, 0, "inst done after reset");
		check_value(data_rsp.done, 0, "data done after reset");
		check_value(mem_req, 0, "mem_req_o after reset");
		check_value(exception, 0, "exception_o after reset");
		check_value(hit_counts, 0, "hit counters after reset");

		fd = $fopen("verification/hierarchy_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			$display("TEST FAILED");
			$fatal(1, "no patterns");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code == 1) begin
				if (tok == "#") begin
					code = $fgets(line_buf, fd);
				end else if (tok == "B") begin
					code = $fscanf(fd, "%h %h %h %h", a, e, a2, e2);
					pair_access(a, e, a2, e2);
				end else begin
					code = $fscanf(fd, "%h %h %h %h", rw, a, d, e);
					single_access((tok == "D") ? 1 : 0, rw, a, d, e);
				end
			end
		end
		$fclose(fd);

		@(negedge clock);
		check_value(exception, exc_expected, "exception after the last access");
		check_value(hit_counts, {32'(l2_hits), 32'(l1_hits[1]), 32'(l1_hits[0])},
			"hit counters {L2, L1D, L1I}");
		$display("TEST OK");
		$finish;
	end

endmodule

/* verification/ext_mem_model.sv */
// behavioral external memory

module ext_mem_model #(
	parameter int WORDS = 4096
) (
	input  logic             clock_i,
	input  logic             rst_i,
	input  logic             mem_req_i,
	input  logic             mem_rw_i,
	input  cache_pkg::addr_t mem_add_i,
	input  cache_pkg::word_t mem_data_i,
	output cache_pkg::word_t mem_data_o,
	output logic             mem_done_o
);
	timeunit 1ns;
	timeprecision 1ps;

	cache_pkg::word_t mem [WORDS];
	integer           seed;
	logic             busy_q;
	int               wait_q;
	int               index;

	// every word starts from its own address
	initial begin
		seed       = 32'h67e;
		mem_done_o <= 1'b0;
		mem_data_o <= '0;
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = 32'h5a000000 | i;
		end
	end

	assign index = int'(mem_add_i) % WORDS;

	// ------------------------------------------------------------
	// handshake with a random delay of a few cycles
	// ------------------------------------------------------------
	always @(posedge clock_i) begin
		if (rst_i) begin
			mem_done_o <= 1'b0;
			mem_data_o <= '0;
			busy_q     <= 1'b0;
			wait_q     <= 0;
		end else begin
			mem_done_o <= 1'b0;
			if (mem_req_i && !mem_done_o) begin
				if (!busy_q) begin
					busy_q <= 1'b1;
					wait_q <= int'($unsigned($random(seed)) % 5);
				end else if (wait_q == 0) begin
					busy_q     <= 1'b0;
					mem_done_o <= 1'b1;
					if (mem_rw_i) begin
						mem[index] <= mem_data_i;
					end else begin
						mem_data_o <= mem[index];
					end
				end else begin
					wait_q <= wait_q - 1;
				end
			end
		end
	end

endmodule

/* verification/clock_gen.sv */
// testbench clock and reset

module clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clock_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD / 2) clock_o = ~clock_o;
	end

	// reset released on the edge after the last reset cycle
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_o);
		rst_o <= 1'b0;
	end

endmodule

/* source/mem_hierarchy_top.sv */
// two-level memory hierarchy top

module mem_hierarchy_top #(
	parameter int L1_LINES    = 16,
	parameter int L2_LINES    = 64,
	parameter int MEM_WORDS   = 4096,
	parameter int MEM_TIMEOUT = 64
) (
	input  logic                clock_i,
	input  logic                rst_i,
	// core ports
	input  cache_pkg::mem_req_t inst_req_i,
	output cache_pkg::mem_rsp_t inst_rsp_o,
	input  cache_pkg::mem_req_t data_req_i,
	output cache_pkg::mem_rsp_t data_rsp_o,
	// external memory, word addressed
	output logic                mem_req_o,
	output logic                mem_rw_o,
	output cache_pkg::addr_t    mem_add_o,
	output cache_pkg::word_t    mem_data_o,
	input  cache_pkg::word_t    mem_data_i,
	input  logic                mem_done_i,
	output logic [1:0]          exception_o,
	// {L2, L1D, L1I}
	output logic [95:0]         hit_counts_o
);

	// ------------------------------------------------------------
	// L1 caches
	// ------------------------------------------------------------
	cache_pkg::mem_req_t inst_miss_req, data_miss_req;
	cache_pkg::mem_rsp_t inst_miss_rsp, data_miss_rsp;
	logic [31:0] l1i_hits, l1d_hits, l2_hits;

	l1_cache #(.LINES(L1_LINES)) l1_inst (
		.clock_i(clock_i), .rst_i(rst_i),
		.core_req_i(inst_req_i), .core_rsp_o(inst_rsp_o),
		.miss_req_o(inst_miss_req), .miss_rsp_i(inst_miss_rsp),
		.hit_count_o(l1i_hits)
	);

	l1_cache #(.LINES(L1_LINES)) l1_data (
		.clock_i(clock_i), .rst_i(rst_i),
		.core_req_i(data_req_i), .core_rsp_o(data_rsp_o),
		.miss_req_o(data_miss_req), .miss_rsp_i(data_miss_rsp),
		.hit_count_o(l1d_hits)
	);

	// ------------------------------------------------------------
	// shared path to memory
	// ------------------------------------------------------------
	cache_pkg::mem_req_t l2_req, mc_req;
	cache_pkg::mem_rsp_t l2_rsp, mc_rsp;
	logic range_err;

	miss_arbiter arbiter (
		.clock_i(clock_i), .rst_i(rst_i),
		.inst_req_i(inst_miss_req), .inst_rsp_o(inst_miss_rsp),
		.data_req_i(data_miss_req), .data_rsp_o(data_miss_rsp),
		.l2_req_o(l2_req), .l2_rsp_i(l2_rsp)
	);

	l2_cache #(.LINES(L2_LINES)) l2 (
		.clock_i(clock_i), .rst_i(rst_i),
		.l1_req_i(l2_req), .l1_rsp_o(l2_rsp),
		.mc_req_o(mc_req), .mc_rsp_i(mc_rsp),
		.range_err_i(range_err), .hit_count_o(l2_hits)
	);

	ext_mem_controller #(.MEM_WORDS(MEM_WORDS), .MEM_TIMEOUT(MEM_TIMEOUT)) mem_ctrl (
		.clock_i(clock_i), .rst_i(rst_i),
		.l2_req_i(mc_req), .l2_rsp_o(mc_rsp), .range_err_o(range_err),
		.mem_req_o(mem_req_o), .mem_rw_o(mem_rw_o),
		.mem_add_o(mem_add_o), .mem_data_o(mem_data_o),
		.mem_data_i(mem_data_i), .mem_done_i(mem_done_i),
		.exception_o(exception_o)
	);

	assign hit_counts_o = {l2_hits, l1d_hits, l1i_hits};

endmodule

/* source/ext_mem_controller.sv */
// external memory controller

module ext_mem_controller #(
	parameter int MEM_WORDS   = 4096,
	parameter int MEM_TIMEOUT = 64
) (
	input  logic                clock_i,
	input  logic                rst_i,
	input  cache_pkg::mem_req_t l2_req_i,
	output cache_pkg::mem_rsp_t l2_rsp_o,
	output logic                range_err_o,
	output logic                mem_req_o,
	output logic                mem_rw_o,
	output cache_pkg::addr_t    mem_add_o,
	output cache_pkg::word_t    mem_data_o,
	input  cache_pkg::word_t    mem_data_i,
	input  logic                mem_done_i,
	output logic [1:0]          exception_o
);

	localparam int TIMER_W = $clog2(MEM_TIMEOUT + 1);

	logic                active_q;
	logic [TIMER_W-1:0]  timer_q;
	cache_pkg::mem_rsp_t rsp_q;
	logic                range_err_q;
	logic [1:0]          exc_q;
	logic                out_of_range;

	assign out_of_range = {8'd0, l2_req_i.addr} >= 32'(MEM_WORDS);

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			active_q    <= 1'b0;
			timer_q     <= '0;
			rsp_q       <= '0;
			range_err_q <= 1'b0;
			exc_q       <= '0;
		end else begin
			rsp_q.done  <= 1'b0;
			range_err_q <= 1'b0;
			// the done cycle still shows the old request
			if (!active_q && l2_req_i.valid && !rsp_q.done) begin
				if (out_of_range) begin
					rsp_q       <= '{done: 1'b1, data: '0};
					range_err_q <= 1'b1;
					exc_q[cache_pkg::EXC_ADDR_RANGE] <= 1'b1;
				end else begin
					active_q <= 1'b1;
					timer_q  <= '0;
				end
			end else if (active_q) begin
				if (mem_done_i) begin
					active_q <= 1'b0;
					rsp_q    <= '{done: 1'b1, data: mem_data_i};
				end else if (timer_q == TIMER_W'(MEM_TIMEOUT - 1)) begin
					// give up on the memory
					active_q <= 1'b0;
					rsp_q    <= '{done: 1'b1, data: '0};
					exc_q[cache_pkg::EXC_MEM_TIMEOUT] <= 1'b1;
				end else begin
					timer_q <= timer_q + 1'b1;
				end
			end
		end
	end

	assign l2_rsp_o    = rsp_q;
	assign range_err_o = range_err_q;
	assign exception_o = exc_q;

	// pins follow the held L2 request
	assign mem_req_o  = active_q;
	assign mem_rw_o   = l2_req_i.rw;
	assign mem_add_o  = l2_req_i.addr;
	assign mem_data_o = l2_req_i.data;

	a_no_bad_mem_req: assert property (@(posedge clock_i) disable iff (rst_i)
		mem_req_o |-> !out_of_range);

endmodule

/* source/l2_cache.sv */
// shared L2 cache, direct mapped, write through

module l2_cache #(
	parameter int LINES = 64
) (
	input  logic                clock_i,
	input  logic                rst_i,
	input  cache_pkg::mem_req_t l1_req_i,
	output cache_pkg::mem_rsp_t l1_rsp_o,
	output cache_pkg::mem_req_t mc_req_o,
	input  cache_pkg::mem_rsp_t mc_rsp_i,
	input  logic                range_err_i,
	output logic [31:0]         hit_count_o
);

	localparam int ADDR_W  = $bits(cache_pkg::addr_t);
	localparam int INDEX_W = $clog2(LINES);
	localparam int TAG_W   = ADDR_W - INDEX_W;

	logic [LINES-1:0]  valid_q;
	logic [TAG_W-1:0]  tag_q [LINES];
	cache_pkg::word_t  data_q [LINES];

	cache_pkg::cache_state_e state_q, state_d;
	logic [31:0] hits_q;

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic               match;
	logic               hit;
	logic               waiting;
	logic               fill_en;
	logic               update_en;

	assign index   = l1_req_i.addr[INDEX_W-1:0];
	assign tag     = l1_req_i.addr[ADDR_W-1:INDEX_W];
	assign match   = valid_q[index] && (tag_q[index] == tag);
	assign hit     = (state_q == cache_pkg::LOOKUP) && !l1_req_i.rw && match;
	assign waiting = (state_q == cache_pkg::MISS_WAIT) || (state_q == cache_pkg::WRITE_WAIT);

	// zero data from a bad address is not cached
	assign fill_en   = (state_q == cache_pkg::MISS_WAIT) && mc_rsp_i.done && !range_err_i;
	assign update_en = (state_q == cache_pkg::WRITE_WAIT) && mc_rsp_i.done && match;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			cache_pkg::IDLE:
				if (l1_req_i.valid) begin
					state_d = cache_pkg::LOOKUP;
				end
			cache_pkg::LOOKUP:
				if (l1_req_i.rw) begin
					state_d = cache_pkg::WRITE_WAIT;
				end else if (match) begin
					state_d = cache_pkg::IDLE;
				end else begin
					state_d = cache_pkg::MISS_WAIT;
				end
			cache_pkg::MISS_WAIT, cache_pkg::WRITE_WAIT:
				if (mc_rsp_i.done) begin
					state_d = cache_pkg::IDLE;
				end
			default: state_d = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q <= cache_pkg::IDLE;
			valid_q <= '0;
			hits_q  <= '0;
		end else begin
			state_q <= state_d;
			hits_q  <= hits_q + {31'd0, hit};
			if (fill_en) begin
				valid_q[index] <= 1'b1;
			end
		end
	end

	// line contents
	always_ff @(posedge clock_i) begin
		if (fill_en) begin
			tag_q[index]  <= tag;
			data_q[index] <= mc_rsp_i.data;
		end
		if (update_en) begin
			data_q[index] <= l1_req_i.data;
		end
	end

	// ------------------------------------------------------------
	// ports
	// ------------------------------------------------------------
	always_comb begin
		if (hit) begin
			l1_rsp_o.done = 1'b1;
			l1_rsp_o.data = data_q[index];
		end else if (waiting) begin
			l1_rsp_o = mc_rsp_i;
		end else begin
			l1_rsp_o = '0;
		end
	end

	always_comb begin
		mc_req_o       = l1_req_i;
		mc_req_o.valid = waiting;
	end

	assign hit_count_o = hits_q;

endmodule

/* source/miss_arbiter.sv */
// L1 miss arbiter, data port first

module miss_arbiter (
	input  logic                clock_i,
	input  logic                rst_i,
	input  cache_pkg::mem_req_t inst_req_i,
	output cache_pkg::mem_rsp_t inst_rsp_o,
	input  cache_pkg::mem_req_t data_req_i,
	output cache_pkg::mem_rsp_t data_rsp_o,
	output cache_pkg::mem_req_t l2_req_o,
	input  cache_pkg::mem_rsp_t l2_rsp_i
);

	logic                busy_q;
	cache_pkg::req_src_e owner_q;
	cache_pkg::req_src_e grant_src;

	// ------------------------------------------------------------
	// grant
	// ------------------------------------------------------------

	// locked to the owner while a request is in flight
	always_comb begin
		if (busy_q) begin
			grant_src = owner_q;
		end else if (data_req_i.valid) begin
			grant_src = cache_pkg::SRC_DATA;
		end else begin
			grant_src = cache_pkg::SRC_INST;
		end
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			busy_q  <= 1'b0;
			owner_q <= cache_pkg::SRC_INST;
		end else if (!busy_q) begin
			owner_q <= grant_src;
			busy_q  <= l2_req_o.valid && !l2_rsp_i.done;
		end else if (l2_rsp_i.done) begin
			busy_q <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// routing
	// ------------------------------------------------------------
	assign l2_req_o = (grant_src == cache_pkg::SRC_DATA) ? data_req_i : inst_req_i;

	// only the owner sees done and data
	always_comb begin
		inst_rsp_o = '0;
		data_rsp_o = '0;
		if (grant_src == cache_pkg::SRC_DATA) begin
			data_rsp_o = l2_rsp_i;
		end else begin
			inst_rsp_o = l2_rsp_i;
		end
	end

	// done reaches exactly one port, and that port is requesting
	a_single_owner: assert property (@(posedge clock_i) disable iff (rst_i)
		l2_rsp_i.done |-> $onehot({inst_rsp_o.done, data_rsp_o.done})
			&& ((grant_src == cache_pkg::SRC_DATA) ? data_req_i.valid : inst_req_i.valid));

endmodule

/* source/l1_cache.sv */
// L1 cache, direct mapped, write through

module l1_cache #(
	parameter int LINES = 16
) (
	input  logic                clock_i,
	input  logic                rst_i,
	input  cache_pkg::mem_req_t core_req_i,
	output cache_pkg::mem_rsp_t core_rsp_o,
	output cache_pkg::mem_req_t miss_req_o,
	input  cache_pkg::mem_rsp_t miss_rsp_i,
	output logic [31:0]         hit_count_o
);

	localparam int ADDR_W  = $bits(cache_pkg::addr_t);
	localparam int INDEX_W = $clog2(LINES);
	localparam int TAG_W   = ADDR_W - INDEX_W;

	// line storage, one word per line
	logic [LINES-1:0]  line_valid_q;
	logic [TAG_W-1:0]  line_tag_q [LINES];
	cache_pkg::word_t  line_data_q [LINES];

	cache_pkg::cache_state_e state_q, state_d;
	logic [31:0] hit_count_q;

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic               tag_match;
	logic               read_hit;
	logic               fill_en;
	logic               update_en;

	assign index     = core_req_i.addr[INDEX_W-1:0];
	assign tag       = core_req_i.addr[ADDR_W-1:INDEX_W];
	assign tag_match = line_valid_q[index] && (line_tag_q[index] == tag);
	assign read_hit  = (state_q == cache_pkg::LOOKUP) && !core_req_i.rw && tag_match;
	assign fill_en   = (state_q == cache_pkg::MISS_WAIT) && miss_rsp_i.done;
	// write only refreshes a line that is already there
	assign update_en = (state_q == cache_pkg::WRITE_WAIT) && miss_rsp_i.done && tag_match;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::IDLE: begin
				if (core_req_i.valid) begin
					state_d = cache_pkg::LOOKUP;
				end
			end
			cache_pkg::LOOKUP: begin
				if (core_req_i.rw) begin
					state_d = cache_pkg::WRITE_WAIT;
				end else if (!tag_match) begin
					state_d = cache_pkg::MISS_WAIT;
				end else begin
					state_d = cache_pkg::IDLE;
				end
			end
			cache_pkg::MISS_WAIT, cache_pkg::WRITE_WAIT: begin
				if (miss_rsp_i.done) begin
					state_d = cache_pkg::IDLE;
				end
			end
			default: state_d = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q      <= cache_pkg::IDLE;
			hit_count_q  <= '0;
			line_valid_q <= '0;
		end else begin
			state_q <= state_d;
			if (read_hit) begin
				hit_count_q <= hit_count_q + 32'd1;
			end
			if (fill_en) begin
				line_valid_q[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (fill_en) begin
			line_tag_q[index]  <= tag;
			line_data_q[index] <= miss_rsp_i.data;
		end else if (update_en) begin
			line_data_q[index] <= core_req_i.data;
		end
	end

	// ------------------------------------------------------------
	// ports
	// ------------------------------------------------------------
	always_comb begin
		core_rsp_o = '0;
		if (read_hit) begin
			core_rsp_o.done = 1'b1;
			core_rsp_o.data = line_data_q[index];
		end else if (state_q == cache_pkg::MISS_WAIT || state_q == cache_pkg::WRITE_WAIT) begin
			core_rsp_o = miss_rsp_i;
		end
	end

	// forwarded request follows the held core request
	always_comb begin
		miss_req_o       = core_req_i;
		miss_req_o.valid = (state_q == cache_pkg::MISS_WAIT) || (state_q == cache_pkg::WRITE_WAIT);
	end

	assign hit_count_o = hit_count_q;

	a_addr_stable: assert property (@(posedge clock_i) disable iff (rst_i)
		(core_req_i.valid && !core_rsp_o.done) |=> $stable(core_req_i.addr));

endmodule

/* source/cache_pkg.sv */
// memory hierarchy shared types

package cache_pkg;

	// ------------------------------------------------------------
	// address and data
	// ------------------------------------------------------------

	// word addressable, same width as the external port
	typedef logic [23:0] addr_t;
	typedef logic [31:0] word_t;

	// ------------------------------------------------------------
	// req/done port pair
	// ------------------------------------------------------------

	// requester side, held stable until done
	typedef struct packed {
		logic  valid;
		logic  rw;	// 1 = write
		addr_t addr;
		word_t data;
	} mem_req_t;

	// responder side, data valid with done
	typedef struct packed {
		logic  done;
		word_t data;
	} mem_rsp_t;

	// ------------------------------------------------------------
	// control encodings
	// ------------------------------------------------------------

	// cache FSM
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		LOOKUP     = 2'd1,
		MISS_WAIT  = 2'd2,
		WRITE_WAIT = 2'd3
	} cache_state_e;

	// owner of the shared L2 port
	typedef enum logic {
		SRC_INST = 1'b0,
		SRC_DATA = 1'b1
	} req_src_e;

	// bit positions in exception_o
	typedef enum logic [0:0] {
		EXC_ADDR_RANGE  = 1'b0,
		EXC_MEM_TIMEOUT = 1'b1
	} exc_e;

endpackage
